/* rtl/adiv_pkg.sv */
package adiv_pkg;

  // operand and result widths of the 16/8 divider
  typedef logic [15:0] dvnd_t;
  typedef logic [7:0]  quot_t;   // also used for divisor values

  // statistics
  typedef logic [7:0]  err_t;    // absolute quotient error
  typedef logic [15:0] stat_t;   // operation / mismatch counts

  // one step per quotient bit
  typedef logic [2:0]  step_t;

  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    ITER,
    CAPTURE
  } ctrl_state_t;

endpackage

/* rtl/div_ctrl_if.sv */
`timescale 1ns/1ps

interface div_ctrl_if;

  logic load;     // latch operands
  logic step;     // one restoring iteration
  logic capture;  // register both results
  logic last;     // final iteration in progress

  modport ctrl (
    output load,
    output step,
    output capture,
    input  last
  );

  modport dp (
    input load,
    input step
  );

  modport mon (
    input capture
  );

endinterface

/* rtl/approx_div_array.sv */
`timescale 1ns/1ps

module approx_div_array #(
  parameter int APPROX_COLS = 6
) (
  input  adiv_pkg::dvnd_t n,
  input  adiv_pkg::quot_t d,
  output adiv_pkg::quot_t q,
  output adiv_pkg::quot_t r
);

  import adiv_pkg::*;

  // row i produces quotient bit i, row 7 is evaluated first
  logic [8:0] pr   [8];  // partial remainder, bit 8 is the shifted-out bit
  logic [8:0] bw   [8];  // borrow chain, bw[i][0] is the row's borrow-in
  quot_t      diff [8];
  quot_t      kept [8];

  genvar i, j;

  generate
    for (i = 7; i >= 0; i--) begin : g_row

      if (i == 7) begin : g_first
        assign pr[i] = n[15:7];  // dividend high bits
      end else begin : g_next
        assign pr[i] = {kept[i+1], n[i]};  // bring down next dividend bit
      end

      assign bw[i][0] = 1'b0;

      for (j = 0; j < 8; j++) begin : g_col
        if (j < APPROX_COLS) begin : g_apx
          // approximate cell, borrow never propagates
          assign diff[i][j]  = pr[i][j] & ~bw[i][j];
          assign bw[i][j+1]  = 1'b0;
        end else begin : g_exact
          assign diff[i][j]  = pr[i][j] ^ d[j] ^ bw[i][j];
          assign bw[i][j+1]  = (~pr[i][j] & d[j]) |
                               (~(pr[i][j] ^ d[j]) & bw[i][j]);
        end
      end

      // subtract succeeds if the top bit was set or no final borrow
      assign q[i]    = pr[i][8] | ~bw[i][8];
      assign kept[i] = q[i] ? diff[i] : pr[i][7:0];  // restore on failure

    end
  endgenerate

  assign r = kept[0];

endmodule

/* rtl/exact_div_seq.sv */
`timescale 1ns/1ps

module exact_div_seq (
  input  logic            clk,
  input  logic            rst_n,
  input  adiv_pkg::dvnd_t n,
  input  adiv_pkg::quot_t d,
  div_ctrl_if.dp          ctl,
  output adiv_pkg::dvnd_t n_hold,
  output adiv_pkg::quot_t d_hold,
  output adiv_pkg::quot_t q,
  output adiv_pkg::quot_t r,
  output logic            ovf
);

  import adiv_pkg::*;

  // remainder in the upper byte, dividend low bits shift out of the
  // lower byte while quotient bits shift in behind them
  dvnd_t      rq;
  logic [8:0] shifted;
  logic [8:0] sub;
  logic       ge;

  always_comb begin
    shifted = {rq[15:8], rq[7]};
    sub     = shifted - {1'b0, d_hold};
    ge      = shifted >= {1'b0, d_hold};  // 9-bit compare
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      n_hold <= '0;
      d_hold <= '0;
      rq     <= '0;
      ovf    <= 1'b0;
    end else if (ctl.load) begin
      n_hold <= n;
      d_hold <= d;
      rq     <= n;
      ovf    <= n[15:8] >= d;  // also catches d == 0
    end else if (ctl.step) begin
      rq <= {(ge ? sub[7:0] : shifted[7:0]), rq[6:0], ge};
    end
  end

  assign q = rq[7:0];
  assign r = rq[15:8];

endmodule

/* rtl/iter_counter.sv */
`timescale 1ns/1ps

module iter_counter (
  input  logic clk,
  input  logic rst_n,
  input  logic clear,
  input  logic enable,
  output logic last
);

  import adiv_pkg::*;

  step_t count;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (enable) begin
      count <= count + 1'b1;  // wraps after the eighth step
    end
  end

  assign last = enable && (count == step_t'(7));

endmodule

/* rtl/div_ctrl_fsm.sv */
`timescale 1ns/1ps

module div_ctrl_fsm (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    start,
  input  logic    last,
  div_ctrl_if.ctrl ctl,
  output logic    cnt_clear,
  output logic    cnt_en,
  output logic    busy,
  output logic    done
);

  import adiv_pkg::*;

  ctrl_state_t state, state_nxt;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:    if (start) state_nxt = LOAD;  // start ignored elsewhere
      LOAD:    state_nxt = ITER;
      ITER:    if (last) state_nxt = CAPTURE;
      CAPTURE: state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
      done  <= 1'b0;
    end else begin
      state <= state_nxt;
      done  <= (state == CAPTURE);  // results valid with this pulse
    end
  end

  // strobes straight from the state
  assign ctl.load    = (state == LOAD);
  assign ctl.step    = (state == ITER);
  assign ctl.capture = (state == CAPTURE);
  assign cnt_clear   = (state == LOAD);
  assign cnt_en      = (state == ITER);
  assign busy        = (state != IDLE);

endmodule

/* rtl/error_monitor.sv */
`timescale 1ns/1ps

module error_monitor (
  input  logic            clk,
  input  logic            rst_n,
  div_ctrl_if.mon         ctl,
  input  logic            clear_stats,
  input  adiv_pkg::quot_t q_exact,
  input  adiv_pkg::quot_t r_exact,
  input  logic            ovf,
  input  adiv_pkg::quot_t q_approx,
  input  adiv_pkg::quot_t r_approx,
  output adiv_pkg::quot_t q_exact_out,
  output adiv_pkg::quot_t r_exact_out,
  output adiv_pkg::quot_t q_approx_out,
  output adiv_pkg::quot_t r_approx_out,
  output logic            ovf_out,
  output adiv_pkg::err_t  abs_err,
  output adiv_pkg::err_t  max_err,
  output adiv_pkg::stat_t mismatch_cnt,
  output adiv_pkg::stat_t op_cnt
);

  import adiv_pkg::*;

  err_t q_diff;

  always_comb begin
    if (ovf) q_diff = '0;  // overflowed ops carry no error
    else if (q_exact >= q_approx) q_diff = q_exact - q_approx;
    else q_diff = q_approx - q_exact;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      q_exact_out  <= '0;
      r_exact_out  <= '0;
      q_approx_out <= '0;
      r_approx_out <= '0;
      ovf_out      <= 1'b0;
      abs_err      <= '0;
      max_err      <= '0;
      mismatch_cnt <= '0;
      op_cnt       <= '0;
    end else if (ctl.capture) begin  // wins over clear_stats
      q_exact_out  <= q_exact;
      r_exact_out  <= r_exact;
      q_approx_out <= q_approx;
      r_approx_out <= r_approx;
      ovf_out      <= ovf;
      abs_err      <= q_diff;
      if (!ovf) begin
        op_cnt <= op_cnt + 1'b1;
        if (q_exact != q_approx) mismatch_cnt <= mismatch_cnt + 1'b1;
        if (q_diff > max_err) max_err <= q_diff;
      end
    end else if (clear_stats) begin
      max_err      <= '0;
      mismatch_cnt <= '0;
      op_cnt       <= '0;
    end
  end

endmodule

/* rtl/adiv_eval_top.sv */
`timescale 1ns/1ps

module adiv_eval_top #(
  parameter int APPROX_COLS = 6
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start,
  input  logic            clear_stats,
  input  adiv_pkg::dvnd_t n,
  input  adiv_pkg::quot_t d,
  output logic            busy,
  output logic            done,
  output adiv_pkg::quot_t q_exact,
  output adiv_pkg::quot_t r_exact,
  output adiv_pkg::quot_t q_approx,
  output adiv_pkg::quot_t r_approx,
  output logic            ovf,
  output adiv_pkg::err_t  abs_err,
  output adiv_pkg::err_t  max_err,
  output adiv_pkg::stat_t mismatch_cnt,
  output adiv_pkg::stat_t op_cnt
);

  import adiv_pkg::*;

  dvnd_t n_hold;
  quot_t d_hold;
  quot_t q_ex, r_ex;   // exact divider results
  quot_t q_ap, r_ap;   // array results
  logic  ovf_ex;
  logic  cnt_clear, cnt_en;

  div_ctrl_if ctl_if ();

  div_ctrl_fsm fsm_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .last      (ctl_if.last),
    .ctl       (ctl_if.ctrl),
    .cnt_clear (cnt_clear),
    .cnt_en    (cnt_en),
    .busy      (busy),
    .done      (done)
  );

  iter_counter cnt_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .clear  (cnt_clear),
    .enable (cnt_en),
    .last   (ctl_if.last)
  );

  exact_div_seq exact_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .n      (n),
    .d      (d),
    .ctl    (ctl_if.dp),
    .n_hold (n_hold),
    .d_hold (d_hold),
    .q      (q_ex),
    .r      (r_ex),
    .ovf    (ovf_ex)
  );

  approx_div_array #(
    .APPROX_COLS (APPROX_COLS)
  ) array_i (
    .n (n_hold),
    .d (d_hold),
    .q (q_ap),
    .r (r_ap)
  );

  error_monitor mon_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctl          (ctl_if.mon),
    .clear_stats  (clear_stats),
    .q_exact      (q_ex),
    .r_exact      (r_ex),
    .ovf          (ovf_ex),
    .q_approx     (q_ap),
    .r_approx     (r_ap),
    .q_exact_out  (q_exact),
    .r_exact_out  (r_exact),
    .q_approx_out (q_approx),
    .r_approx_out (r_approx),
    .ovf_out      (ovf),
    .abs_err      (abs_err),
    .max_err      (max_err),
    .mismatch_cnt (mismatch_cnt),
    .op_cnt       (op_cnt)
  );

endmodule

/* test/adiv_eval_tb.sv */
`timescale 1ns/1ps

module adiv_eval_tb;

  import adiv_pkg::*;

  localparam int APPROX_COLS     = 6;
  localparam int N_OPS           = 75;                // operations issued by all tests
  localparam int WATCHDOG_CYCLES = N_OPS * 12 + 100;

  logic  clk;
  logic  rst_n;
  logic  start;
  logic  clear_stats;
  dvnd_t n;
  quot_t d;
  logic  busy;
  logic  done;
  quot_t q_exact, r_exact, q_approx, r_approx;
  logic  ovf;
  err_t  abs_err, max_err;
  stat_t mismatch_cnt, op_cnt;

  integer seed = 32'hd105;
  int     pass_cnt = 0;
  int     fail_cnt = 0;

  // running statistics model
  stat_t model_ops  = '0;
  stat_t model_mism = '0;
  err_t  model_max  = '0;

  adiv_eval_top #(
    .APPROX_COLS (APPROX_COLS)
  ) adiv_eval_top_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .clear_stats  (clear_stats),
    .n            (n),
    .d            (d),
    .busy         (busy),
    .done         (done),
    .q_exact      (q_exact),
    .r_exact      (r_exact),
    .q_approx     (q_approx),
    .r_approx     (r_approx),
    .ovf          (ovf),
    .abs_err      (abs_err),
    .max_err      (max_err),
    .mismatch_cnt (mismatch_cnt),
    .op_cnt       (op_cnt)
  );

  always #50 clk = ~clk;

  task automatic check_quot(input string what, input quot_t got, input quot_t exp);
    if (got !== exp) begin
      $display("error %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      fail_cnt++;
    end else pass_cnt++;
  endtask

  task automatic check_err(input string what, input err_t got, input err_t exp);
    if (got !== exp) begin
      $display("error %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      fail_cnt++;
    end else pass_cnt++;
  endtask

  task automatic check_stat(input string what, input stat_t got, input stat_t exp);
    if (got !== exp) begin
      $display("error %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      fail_cnt++;
    end else pass_cnt++;
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error %0t ns: %s is %b, expected %b", $time, what, got, exp);
      fail_cnt++;
    end else pass_cnt++;
  endtask

  // restoring array rebuilt cell by cell
  task automatic approx_model(input dvnd_t a, input quot_t b, output quot_t q, output quot_t r);
    logic [8:0] pr;
    quot_t      kept;
    quot_t      diff;
    logic       bw;
    kept = a[15:8];
    for (int i = 7; i >= 0; i--) begin
      pr = {kept, a[i]};
      bw = 1'b0;
      for (int j = 0; j < 8; j++) begin
        if (j < APPROX_COLS) begin
          diff[j] = pr[j] & ~bw;
          bw      = 1'b0;
        end else begin
          diff[j] = pr[j] ^ b[j] ^ bw;
          bw      = (~pr[j] & b[j]) | (~(pr[j] ^ b[j]) & bw);
        end
      end
      q[i] = pr[8] | ~bw;
      kept = q[i] ? diff : pr[7:0];
    end
    r = kept;
  endtask

  task automatic rand_operands(output dvnd_t a, output quot_t b);
    integer r1, r2, r3;
    r1 = $random(seed);
    r2 = $random(seed);
    r3 = $random(seed);
    b  = quot_t'(r1);
    if (b == 0) b = 8'd1;
    a = {quot_t'((r2 & 255) % b), quot_t'(r3)};  // high byte below divisor
  endtask

  task automatic start_op(input dvnd_t a, input quot_t b);
    @(posedge clk);
    #5;
    n     = a;
    d     = b;
    start = 1'b1;
    @(posedge clk);  // start sampled here
    #5;
    start = 1'b0;
  endtask

  task automatic wait_done(output int cycles);
    logic seen;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < 20) begin
      @(posedge clk);
      #1;
      cycles++;
      seen = done;
    end
    if (!seen) begin
      $display("done never came, gave up after %0d cycles at %0t ns", cycles, $time);
      fail_cnt++;
      cycles = -1;
    end
  endtask

  task automatic check_result(input dvnd_t a, input quot_t b);
    quot_t qm, rm;
    logic  ovf_m;
    err_t  diff_m;
    int    qi, ri;
    ovf_m = (b == 0) || (int'(a) / int'(b) > 255);  // quotient does not fit in a byte
    approx_model(a, b, qm, rm);
    check_bit("ovf", ovf, ovf_m);
    check_quot("q_approx", q_approx, qm);
    check_quot("r_approx", r_approx, rm);
    diff_m = '0;
    if (!ovf_m) begin
      qi = int'(a) / int'(b);
      ri = int'(a) % int'(b);
      check_quot("q_exact", q_exact, quot_t'(qi));
      check_quot("r_exact", r_exact, quot_t'(ri));
      diff_m = (qi >= qm) ? err_t'(qi - qm) : err_t'(qm - qi);
      model_ops++;
      if (quot_t'(qi) != qm) model_mism++;
      if (diff_m > model_max) model_max = diff_m;
    end
    check_err("abs_err", abs_err, diff_m);
  endtask

  task automatic run_op(input dvnd_t a, input quot_t b);
    int cycles;
    start_op(a, b);
    wait_done(cycles);
    if (cycles > 0 && cycles != 10) begin
      $display("done came %0d cycles after start instead of 10, at %0t ns", cycles, $time);
      fail_cnt++;
    end
    check_result(a, b);
  endtask

  task automatic report_test(input string name, input int fails_before);
    $display("%s finished with %0d failures", name, fail_cnt - fails_before);
  endtask

  task automatic test_reset();
    int f0;
    f0 = fail_cnt;
    check_bit("busy", busy, 1'b0);
    check_bit("done", done, 1'b0);
    check_bit("ovf", ovf, 1'b0);
    check_quot("q_exact", q_exact, '0);
    check_quot("r_exact", r_exact, '0);
    check_quot("q_approx", q_approx, '0);
    check_quot("r_approx", r_approx, '0);
    check_err("abs_err", abs_err, '0);
    check_err("max_err", max_err, '0);
    check_stat("mismatch_cnt", mismatch_cnt, '0);
    check_stat("op_cnt", op_cnt, '0);
    report_test("reset test", f0);
  endtask

  task automatic test_exact();
    int f0;
    f0 = fail_cnt;
    run_op(16'h00ab, 8'd1);    // divisor one
    run_op(16'h0000, 8'h55);   // zero dividend
    run_op(16'hfeff, 8'hff);   // quotient 255
    run_op(16'h3086, 8'h7b);   // remainder is divisor minus one
    report_test("exact path test", f0);
  endtask

  task automatic test_approx();
    dvnd_t a;
    quot_t b;
    int    f0;
    f0 = fail_cnt;
    for (int k = 0; k < 60; k++) begin
      rand_operands(a, b);
      run_op(a, b);
    end
    report_test("approximate path test", f0);
  endtask

  task automatic test_overflow();
    stat_t ops0, mism0;
    int    f0;
    f0    = fail_cnt;
    ops0  = op_cnt;
    mism0 = mismatch_cnt;
    run_op(16'h1234, 8'h00);
    run_op(16'h3a5c, 8'h3a);
    check_stat("op_cnt", op_cnt, ops0);
    check_stat("mismatch_cnt", mismatch_cnt, mism0);
    report_test("overflow test", f0);
  endtask

  task automatic test_busy();
    int cycles;
    int extra;
    int f0;
    f0    = fail_cnt;
    extra = 0;
    start_op(16'h2d91, 8'h47);
    repeat (2) @(posedge clk);
    #5;
    check_bit("busy", busy, 1'b1);
    n     = 16'h0310;  // second request while busy
    d     = 8'h09;
    start = 1'b1;
    @(posedge clk);
    #5;
    start = 1'b0;
    wait_done(cycles);
    if (cycles > 0 && cycles != 7) begin
      $display("done came at the wrong time after the ignored start, at %0t ns", $time);
      fail_cnt++;
    end
    check_bit("busy with done", busy, 1'b0);
    check_result(16'h2d91, 8'h47);
    repeat (15) begin
      @(posedge clk);
      #1;
      if (done) extra++;
    end
    if (extra != 0) begin
      $display("start during busy was not ignored, saw %0d extra done pulses", extra);
      fail_cnt++;
    end
    report_test("busy protection test", f0);
  endtask

  task automatic test_stats();
    dvnd_t a;
    quot_t b;
    int    f0;
    f0 = fail_cnt;
    run_op(16'h7fff, 8'hc3);
    run_op(16'h0101, 8'h02);
    for (int k = 0; k < 6; k++) begin
      rand_operands(a, b);
      run_op(a, b);
    end
    check_stat("op_cnt", op_cnt, model_ops);
    check_stat("mismatch_cnt", mismatch_cnt, model_mism);
    check_err("max_err", max_err, model_max);
    @(posedge clk);
    #5;
    clear_stats = 1'b1;
    @(posedge clk);
    #5;
    clear_stats = 1'b0;
    model_ops   = '0;
    model_mism  = '0;
    model_max   = '0;
    check_stat("op_cnt after clear", op_cnt, '0);
    check_stat("mismatch_cnt after clear", mismatch_cnt, '0);
    check_err("max_err after clear", max_err, '0);
    report_test("statistics test", f0);
  endtask

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    start       = 1'b0;
    clear_stats = 1'b0;
    n           = '0;
    d           = '0;
    repeat (4) @(posedge clk);
    #5;
    rst_n = 1'b1;
    test_reset();
    test_exact();
    test_approx();
    test_overflow();
    test_busy();
    test_stats();
    $display("checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

/* adiv_eval_top.f */
rtl/adiv_pkg.sv
rtl/div_ctrl_if.sv
rtl/approx_div_array.sv
rtl/exact_div_seq.sv
rtl/iter_counter.sv
rtl/div_ctrl_fsm.sv
rtl/error_monitor.sv
rtl/adiv_eval_top.sv
test/adiv_eval_tb.sv
